/* hdl/dac_interleave.sv */
module dac_interleave
(
  input  logic                  aclk,
  input  logic                  ddr_clk,
  input  logic                  arst_n,
  input  logic                  locked,
  input  logic                  sample_valid,
  input  dac_pkg::sample_pair_t samples,
  output dac_pkg::dac_pins_t    pins
);

  import dac_pkg::*;

  sample_pair_t pair_q;
  logic         rst_flag;
  logic         blank;
  dac_code_t    dat_q;
  logic         rst_q;
  logic         sel_q;
  logic         wrt_q;
  logic         clk_q;

  // Flipping the sign bit turns two's complement into offset binary
  function automatic dac_code_t to_offset(input dac_code_t code);
    return {~code[dac_width-1], code[dac_width-2:0]};
  endfunction

  assign blank = !locked || !sample_valid;

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pair_q   <= '0;
      rst_flag <= 1'b1;   // DAC held in reset until the first valid pair
    end
    else
    begin
      if (blank)
        pair_q <= '0;
      else
      begin
        pair_q.chan_a <= to_offset(samples.chan_a);
        pair_q.chan_b <= to_offset(samples.chan_b);
      end
      rst_flag <= blank;
    end
  end

  ddr_out #(.payload_t(dac_code_t)) dat_out
  (
    .aclk   (aclk),
    .arst_n (arst_n),
    .d1     (pair_q.chan_a),
    .d2     (pair_q.chan_b),
    .q      (dat_q)
  );

  ddr_out #(.payload_t(logic)) rst_out
  (
    .aclk   (aclk),
    .arst_n (arst_n),
    .d1     (rst_flag),
    .d2     (rst_flag),
    .q      (rst_q)
  );

  ddr_out #(.payload_t(logic)) sel_out
  (
    .aclk   (aclk),
    .arst_n (arst_n),
    .d1     (1'b0),
    .d2     (1'b1),
    .q      (sel_q)
  );

  // Write strobe and DAC clock run on the shifted clock
  ddr_out #(.payload_t(logic)) wrt_out
  (
    .aclk   (ddr_clk),
    .arst_n (arst_n),
    .d1     (1'b0),
    .d2     (1'b1),
    .q      (wrt_q)
  );

  ddr_out #(.payload_t(logic)) clk_out
  (
    .aclk   (ddr_clk),
    .arst_n (arst_n),
    .d1     (1'b0),
    .d2     (1'b1),
    .q      (clk_q)
  );

  assign pins = '{dat: dat_q, rst: rst_q, sel: sel_q, wrt: wrt_q, clk: clk_q};

  a_blank_pair: assert property (
    @(posedge aclk) disable iff (!arst_n)
    rst_flag |-> (pair_q == '0)
  )
  else
    $error("dac_interleave: pair not blanked while rst flag set");

  a_rst_follow: assert property (
    @(posedge aclk) disable iff (!arst_n)
    1'b1 |=> (rst_flag == $past(blank))
  )
  else
    $error("dac_interleave: rst flag does not follow lock and valid");

endmodule

/* hdl/dac_pkg.sv */
package dac_pkg;

  localparam int dac_width = 14;

  // Two's complement from the generators and offset binary on the pins
  typedef logic [dac_width-1:0] dac_code_t;

  typedef struct packed
  {
    dac_code_t chan_a;   // Sent in the high half of aclk
    dac_code_t chan_b;   // Sent in the low half of aclk
  } sample_pair_t;

  typedef struct packed
  {
    dac_code_t dat;      // Interleaved DDR data bus
    logic      rst;
    logic      sel;      // Low for channel A and high for channel B
    logic      wrt;
    logic      clk;
  } dac_pins_t;

endpackage

/* hdl/dac_subsys.sv */
module dac_subsys
(
  input  logic               aclk,
  input  logic               ddr_clk,
  input  logic               arst_n,
  input  logic               locked,
  input  logic               run,
  input  gen_pkg::gen_cfg_t  cfg_a,
  input  gen_pkg::gen_cfg_t  cfg_b,
  output dac_pkg::dac_pins_t pins
);

  import dac_pkg::*;

  dac_code_t    sample_a;
  dac_code_t    sample_b;
  sample_pair_t samples;
  logic         sample_valid;

  assign sample_valid = run;   // The stream side is always ready
  assign samples      = '{chan_a: sample_a, chan_b: sample_b};

  wave_gen gen_a
  (
    .aclk   (aclk),
    .arst_n (arst_n),
    .enable (run && locked),
    .cfg    (cfg_a),
    .sample (sample_a)
  );

  wave_gen gen_b
  (
    .aclk   (aclk),
    .arst_n (arst_n),
    .enable (run && locked),
    .cfg    (cfg_b),
    .sample (sample_b)
  );

  dac_interleave iface
  (
    .aclk         (aclk),
    .ddr_clk      (ddr_clk),
    .arst_n       (arst_n),
    .locked       (locked),
    .sample_valid (sample_valid),
    .samples      (samples),
    .pins         (pins)
  );

endmodule

/* hdl/ddr_out.sv */
module ddr_out #
(
  parameter type payload_t = logic
)
(
  input  logic     aclk,
  input  logic     arst_n,
  input  payload_t d1,
  input  payload_t d2,
  output payload_t q
);

  payload_t d1_rise;
  payload_t d2_rise;
  payload_t d2_fall;

  // Both inputs are taken on the rising edge as in a same-edge output cell
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      d1_rise <= '0;
      d2_rise <= '0;
    end
    else
    begin
      d1_rise <= d1;
      d2_rise <= d2;
    end
  end

  // Second half moves to the falling edge
  always_ff @(negedge aclk or negedge arst_n)
  begin
    if (!arst_n)
      d2_fall <= '0;
    else
      d2_fall <= d2_rise;
  end

  assign q = aclk ? d1_rise : d2_fall;   // Clock level picks the half

endmodule

/* hdl/gen_pkg.sv */
package gen_pkg;

  localparam int phase_width = 24;

  typedef logic [phase_width-1:0] phase_t;

  typedef enum logic [1:0]
  {
    mode_off    = 2'd0,
    mode_dc     = 2'd1,
    mode_square = 2'd2,
    mode_saw    = 2'd3
  } wave_mode_t;

  // One channel's settings stay steady while the generator runs
  typedef struct packed
  {
    wave_mode_t         mode;
    phase_t             step;   // Phase increment per aclk cycle
    dac_pkg::dac_code_t amp;    // Signed, two's complement
  } gen_cfg_t;

endpackage

/* hdl/wave_gen.sv */
module wave_gen
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               enable,
  input  gen_pkg::gen_cfg_t  cfg,
  output dac_pkg::dac_code_t sample
);

  import dac_pkg::*;
  import gen_pkg::*;

  phase_t    phase;
  dac_code_t neg_amp;
  dac_code_t saw_code;
  logic      phase_msb;

  // Phase accumulator wraps modulo 2^phase_width
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
      phase <= '0;
    else if (!enable)
      phase <= '0;   // Restart from zero on the next run
    else
      phase <= phase + cfg.step;
  end

  assign phase_msb = phase[phase_width-1];
  assign neg_amp   = -cfg.amp;
  assign saw_code  = phase[phase_width-1 -: dac_width];   // Top bits read as signed

  always_comb
  begin
    case (cfg.mode)
      mode_off:
        sample = '0;
      mode_dc:
        sample = cfg.amp;
      mode_square:
      begin
        if (phase_msb)
          sample = neg_amp;
        else
          sample = cfg.amp;
      end
      mode_saw:
        sample = saw_code;
      default:
        sample = '0;
    endcase
  end

  // Accumulator is cleared one cycle after the enable drops
  a_phase_clear: assert property (
    @(posedge aclk) disable iff (!arst_n)
    !enable |=> (phase == '0)
  )
  else
    $error("wave_gen: phase not cleared after enable low");

  // Square output stays on the two levels set by amp
  a_square_levels: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (cfg.mode == mode_square) |-> (sample == cfg.amp || sample == neg_amp)
  )
  else
    $error("wave_gen: square sample %0h is not +/- amp", sample);

endmodule

/* src.f */
hdl/dac_pkg.sv
hdl/gen_pkg.sv
hdl/ddr_out.sv
hdl/wave_gen.sv
hdl/dac_interleave.sv
hdl/dac_subsys.sv
verif/dac_subsys_tb.sv

/* verif/dac_subsys_tb.sv */
module dac_subsys_tb;

  import dac_pkg::*;
  import gen_pkg::*;

  localparam int period       = 40;
  localparam int reset_cycles = 10;
  localparam int len_reset    = reset_cycles + 12;
  localparam int len_ctrl     = 8;
  localparam int len_dc       = 24;
  localparam int len_square   = 42;
  localparam int len_saw      = 56;
  localparam int drain_cycles = 3;
  localparam int total_cycles = len_reset + len_ctrl + len_dc + len_square + len_saw
                                + drain_cycles;

  logic      aclk;
  logic      ddr_clk;
  logic      early_clk;   // Copy of aclk at the input drive point
  logic      arst_n;
  logic      locked;
  logic      run;
  gen_cfg_t  cfg_a;
  gen_cfg_t  cfg_b;
  dac_pins_t pins;

  phase_t    phase_a;
  phase_t    phase_b;
  dac_code_t pair_a;      // Model of the pair register
  dac_code_t pair_b;
  logic      flag;        // Model of the reset flag
  dac_code_t exp_dat_a;   // Expected pins one stage after the pair
  dac_code_t exp_dat_b;
  logic      exp_rst;
  logic      started;
  logic      ctrl_live;

  int errors;
  int err_mark;
  int tests_passed;
  int tests_failed;

  dac_subsys UUT
  (
    .aclk    (aclk),
    .ddr_clk (ddr_clk),
    .arst_n  (arst_n),
    .locked  (locked),
    .run     (run),
    .cfg_a   (cfg_a),
    .cfg_b   (cfg_b),
    .pins    (pins)
  );

  always #(period / 2) aclk = ~aclk;

  always @(aclk) ddr_clk <= #(period / 4) aclk;   // Quarter period shift

  always @(aclk) early_clk <= #5 aclk;

  function automatic dac_code_t offset_code(input dac_code_t code);
    return code ^ dac_code_t'(1 << (dac_width - 1));
  endfunction

  // Expected sample from phase and mode
  function automatic dac_code_t model_sample(input gen_cfg_t cfg, input phase_t ph);
    dac_code_t code;
    case (cfg.mode)
      mode_dc:     code = cfg.amp;
      mode_square: code = ph[phase_width-1] ? -cfg.amp : cfg.amp;
      mode_saw:    code = ph[phase_width-1 -: dac_width];
      default:     code = '0;
    endcase
    return code;
  endfunction

  function automatic phase_t rand_step(input int unsigned base);
    return phase_t'(base + ($urandom % 32'h200000));
  endfunction

  function automatic dac_code_t rand_amp();
    return dac_code_t'($urandom);
  endfunction

  // Reference model advances on every rising edge
  always @(posedge aclk)
  begin
    logic blank;
    started = 1'b1;
    if (!arst_n)
    begin
      phase_a   = '0;
      phase_b   = '0;
      pair_a    = '0;
      pair_b    = '0;
      flag      = 1'b1;
      exp_dat_a = '0;
      exp_dat_b = '0;
      exp_rst   = 1'b0;   // DDR cells clear so rst only rises after release
      ctrl_live = 1'b0;
    end
    else
    begin
      exp_dat_a = pair_a;
      exp_dat_b = pair_b;
      exp_rst   = flag;
      blank     = !(locked && run);
      pair_a    = blank ? '0 : offset_code(model_sample(cfg_a, phase_a));
      pair_b    = blank ? '0 : offset_code(model_sample(cfg_b, phase_b));
      flag      = blank;
      phase_a   = blank ? '0 : phase_t'(phase_a + cfg_a.step);
      phase_b   = blank ? '0 : phase_t'(phase_b + cfg_b.step);
      ctrl_live = 1'b1;
    end
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    $display("[FAIL] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
  endtask

  // Mid-high point is the ddr_clk rise and mid-low point its fall
  a_dat_high: assert property (@(posedge ddr_clk) disable iff (!started)
    pins.dat == exp_dat_a)
  else
    report_value("pins.dat high half", exp_dat_a, pins.dat);

  a_dat_low: assert property (@(negedge ddr_clk) disable iff (!started)
    pins.dat == exp_dat_b)
  else
    report_value("pins.dat low half", exp_dat_b, pins.dat);

  a_rst_high: assert property (@(posedge ddr_clk) disable iff (!started)
    pins.rst == exp_rst)
  else
    report_value("pins.rst high half", exp_rst, pins.rst);

  a_rst_low: assert property (@(negedge ddr_clk) disable iff (!started)
    pins.rst == exp_rst)
  else
    report_value("pins.rst low half", exp_rst, pins.rst);

  a_sel_high: assert property (@(posedge ddr_clk) disable iff (!ctrl_live)
    pins.sel == 1'b0)
  else
    report_value("pins.sel high half", 1'b0, pins.sel);

  a_sel_low: assert property (@(negedge ddr_clk) disable iff (!ctrl_live)
    pins.sel == 1'b1)
  else
    report_value("pins.sel low half", 1'b1, pins.sel);

  // ddr_clk is still low at aclk rise + 5 so the cells show D2
  a_wrt_rise: assert property (@(posedge early_clk) disable iff (!ctrl_live)
    pins.wrt == 1'b1)
  else
    report_value("pins.wrt at aclk rise", 1'b1, pins.wrt);

  a_clk_rise: assert property (@(posedge early_clk) disable iff (!ctrl_live)
    pins.clk == 1'b1)
  else
    report_value("pins.clk at aclk rise", 1'b1, pins.clk);

  a_wrt_fall: assert property (@(negedge early_clk) disable iff (!ctrl_live)
    pins.wrt == 1'b0)
  else
    report_value("pins.wrt at aclk fall", 1'b0, pins.wrt);

  a_clk_fall: assert property (@(negedge early_clk) disable iff (!ctrl_live)
    pins.clk == 1'b0)
  else
    report_value("pins.clk at aclk fall", 1'b0, pins.clk);

  task automatic next_cycle(input int n);
    repeat (n)
    begin
      @(posedge aclk);
      #5;
    end
  endtask

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  initial
  begin
    #((total_cycles + 50) * period);
    $display("Watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  initial
  begin
    phase_t step_a;
    phase_t step_b;
    int     i;
    void'($urandom(32'ha0c3));
    aclk = 1'b0;
    ddr_clk = 1'b0;
    early_clk = 1'b0;
    arst_n = 1'b0;
    locked = 1'b0;
    run = 1'b0;
    cfg_a = '0;
    cfg_b = '0;
    started = 1'b0;
    ctrl_live = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;

    begin_test();
    next_cycle(reset_cycles);
    arst_n = 1'b1;
    locked = 1'b1;   // Locked but not running
    next_cycle(4);
    locked = 1'b0;
    run = 1'b1;
    next_cycle(4);
    locked = 1'b1;
    next_cycle(4);
    end_test("reset_blank");

    begin_test();
    cfg_a = '{mode: mode_dc, step: '0, amp: 14'h1555};
    next_cycle(len_ctrl);
    end_test("control_pins");

    begin_test();
    for (i = 0; i < 4; i++)
    begin
      cfg_a = '{mode: mode_dc, step: rand_step(0), amp: rand_amp()};
      cfg_b = '{mode: mode_off, step: rand_step(0), amp: rand_amp()};
      next_cycle(6);
    end
    end_test("dc_off");

    begin_test();
    run = 1'b0;
    step_a = rand_step(32'h080000);
    step_b = rand_step(32'h080000);
    if (step_b == step_a)
      step_b = step_b + 24'h000101;
    cfg_a = '{mode: mode_square, step: step_a, amp: rand_amp()};
    cfg_b = '{mode: mode_square, step: step_b, amp: rand_amp()};
    next_cycle(2);
    run = 1'b1;
    next_cycle(40);
    end_test("square");

    begin_test();
    run = 1'b0;
    cfg_a = '{mode: mode_saw, step: rand_step(32'h100000), amp: '0};
    cfg_b = '{mode: mode_saw, step: rand_step(32'h100000), amp: '0};
    next_cycle(2);
    run = 1'b1;
    next_cycle(30);   // Several accumulator wraps
    run = 1'b0;
    next_cycle(4);
    run = 1'b1;
    next_cycle(20);
    end_test("saw_restart");

    next_cycle(drain_cycles);
    $display("Summary: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
